// ==== vlog.f ====
+incdir+verilog
verilog/abc80_kbd_pkg.sv
verilog/scancode_map.sv
verilog/kbd_control.sv
verilog/key_queue.sv
verilog/abc80_kbd.sv
tests/abc80_kbd_assert.sv
tests/abc80_kbd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the keyboard testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module abc80_kbd_tb -o abc80_kbd_sim \
	&& ./obj_dir/abc80_kbd_sim > sim.log 2>&1 \
	; cat sim.log 2>/dev/null \
	; [ -s sim.log ] && ! grep -q "=== FAIL ===" sim.log \
	|| { echo "Simulation did not pass"; exit 1; }
echo "Simulation passed"

// ==== tests/abc80_kbd_tb.sv ====
// Keyboard unit testbench with reference model, port byte comparison and timeout
`include "abc80_kbd_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module abc80_kbd_tb import abc80_kbd_pkg::*; ();

	localparam int DRAIN_PERIOD = 1 << `KEY_PACE_W; // Clocks between drain edges
	localparam logic [7:0] LETTER_SC [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B,
		8'h34, 8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15,
		8'h2D, 8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
	localparam logic [7:0] NAT_SC [5] = '{8'h55, 8'h54, 8'h5B, 8'h4C, 8'h52};
	localparam logic [6:0] NAT_BASE [5] = '{7'h40, 7'h5D, 7'h5E, 7'h5C, 7'h5B};
	localparam logic [7:0] ROW_SC [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E,
		8'h36, 8'h3D, 8'h3E, 8'h46};
	localparam logic [7:0] PAD_SC [10] = '{8'h70, 8'h69, 8'h72, 8'h7A, 8'h6B, 8'h73,
		8'h74, 8'h6C, 8'h75, 8'h7D};
	localparam logic [7:0] PUNCT_SC [6] = '{8'h41, 8'h49, 8'h4A, 8'h4E, 8'h5D, 8'h0E};
	localparam logic [6:0] PUNCT_LO [6] = '{7'h2C, 7'h2E, 7'h2D, 7'h2B, 7'h27, 7'h3C};
	localparam logic [6:0] PUNCT_HI [6] = '{7'h3B, 7'h3A, 7'h5F, 7'h3F, 7'h2A, 7'h3E};

	logic        CLK12;
	logic        RESET;
	logic        key_strobe;
	logic        key_pressed;
	logic        key_extended;
	logic [7:0]  key_code;
	key_entry_t  key_byte;
	logic        upcase;

	logic [9:0]  ev_q [$]; // {pressed, extended, code}
	logic [7:0]  exp_q [$]; // Port bytes still to come
	logic [7:0]  last_m; // Newest entry in the modelled ring
	logic [7:0]  prev_byte;
	logic [7:0]  want;
	logic        shift_m;
	logic        ctrl_m;
	logic        caps_m;
	logic [31:0] lfsr_state;
	int unsigned edge_cnt; // Edges since reset release
	int unsigned cycles;
	int unsigned cycle_limit;

	abc80_kbd UUT (
		.CLK12        (CLK12),
		.RESET        (RESET),
		.key_strobe   (key_strobe),
		.key_pressed  (key_pressed),
		.key_extended (key_extended),
		.key_code     (key_code),
		.key_byte     (key_byte),
		.upcase       (upcase)
	);

	always #10 CLK12 = ~CLK12;

	task automatic stop_run;
		$display("=== FAIL ===");
		$fatal(1, "Run stopped on the first error");
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
			stop_run();
		end
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1
	endfunction

	function automatic int random_gap();
		int extra;
		extra = 0;
		for (int b = 0; b < 6; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			extra = (extra << 1) | int'(lfsr_state[0]);
		end
		return 600 + extra;
	endfunction

	// ==========================================================================
	// Reference translation, returns {hit, code}
	// ==========================================================================

	function automatic logic [7:0] translate(input logic ext, input logic [7:0] sc,
			input logic sh, input logic ct, input logic up);
		logic [6:0] lc;
		lc = (sh == up) ? 7'h20 : 7'h00; // Lower case when shift matches caps
		if (ext) begin
			if (ct || sh)
				return 8'h00;
			case (sc)
				8'h5A: return {1'b1, 7'h0D};
				8'h6B: return {1'b1, 7'h08};
				8'h74: return {1'b1, 7'h09};
				default: return 8'h00;
			endcase
		end
		if (ct) begin
			if (sc == 8'h0E)
				return {1'b1, 7'h7F};
			if (!sh && sc == 8'h21)
				return {1'b1, 7'h03};
			if (!sh && sc == 8'h22)
				return {1'b1, 7'h18};
			return 8'h00;
		end
		for (int i = 0; i < 26; i++)
			if (sc == LETTER_SC[i])
				return {1'b1, (7'h41 + 7'(i)) | lc};
		for (int i = 0; i < 5; i++)
			if (sc == NAT_SC[i])
				return {1'b1, NAT_BASE[i] | lc};
		for (int i = 0; i < 10; i++) begin
			if (sc == ROW_SC[i] && !sh)
				return {1'b1, 7'h30 + 7'(i)};
			if (sc == ROW_SC[i])
				return {1'b1, (i == 0) ? 7'h3D : 7'h20 + 7'(i)}; // Shifted symbol
			if (sc == PAD_SC[i])
				return sh ? 8'h00 : {1'b1, 7'h30 + 7'(i)};
		end
		for (int i = 0; i < 6; i++)
			if (sc == PUNCT_SC[i])
				return {1'b1, sh ? PUNCT_HI[i] : PUNCT_LO[i]};
		if (!sh && sc == 8'h29)
			return {1'b1, 7'h20};
		if (!sh && sc == 8'h66)
			return {1'b1, 7'h08};
		if (!sh && sc == 8'h5A)
			return {1'b1, 7'h0D};
		return 8'h00;
	endfunction

	// Ring model with release insertion for a held key
	task automatic record_entry(input logic [7:0] e);
		if (e != last_m) begin
			if (e[7] && last_m[7])
				exp_q.push_back({1'b0, last_m[6:0]});
			exp_q.push_back(e);
			last_m = e;
		end
	endtask

	task automatic add(input logic pr, input logic ex, input logic [7:0] sc);
		ev_q.push_back({pr, ex, sc});
	endtask

	task automatic tap(input logic ex, input logic [7:0] sc);
		add(1'b1, ex, sc);
		add(1'b0, ex, sc);
	endtask

	// Called 2 ns after a rising edge, returns at the same phase
	task automatic issue_event(input logic [9:0] ev);
		logic [7:0] res;
		if (!ev[8] && (ev[7:0] == `SC_LSHIFT || ev[7:0] == `SC_RSHIFT)) begin
			shift_m = ev[9];
		end else if (ev[7:0] == `SC_CTRL) begin
			ctrl_m = ev[9];
		end else if (!ev[8] && ev[7:0] == `SC_CAPS) begin
			if (ev[9])
				caps_m = !caps_m;
		end else begin
			res = translate(ev[8], ev[7:0], shift_m, ctrl_m, caps_m);
			if (res[7])
				record_entry({ev[9], res[6:0]});
		end
		key_strobe   = 1'b1;
		key_pressed  = ev[9];
		key_extended = ev[8];
		key_code     = ev[7:0];
		@(posedge CLK12);
		#2;
		key_strobe = 1'b0;
		check(32'(upcase), 32'(caps_m), "upcase after key strobe");
		repeat (random_gap()) @(posedge CLK12);
		#2;
	endtask

	// ==========================================================================
	// Comparing process, sampled mid-cycle
	// ==========================================================================

	always @(posedge CLK12) begin
		cycles <= cycles + 1;
		if (!RESET)
			edge_cnt <= edge_cnt + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			stop_run();
		end
	end

	always @(negedge CLK12) begin
		if (!RESET && key_byte !== prev_byte) begin
			check(edge_cnt % DRAIN_PERIOD, 0, "key_byte changed off a drain edge");
			if (exp_q.size() == 0) begin
				$display("The key port changed to %0h with no entry pending", key_byte);
				stop_run();
			end
			want = exp_q.pop_front();
			check(32'(key_byte), 32'(want), "key port byte");
			prev_byte = key_byte;
		end
	end

	initial begin
		CLK12        = 1'b0;
		RESET        = 1'b1;
		key_strobe   = 1'b0;
		key_pressed  = 1'b0;
		key_extended = 1'b0;
		key_code     = 8'h00;
		last_m       = 8'h00;
		prev_byte    = 8'h00;
		shift_m      = 1'b0;
		ctrl_m       = 1'b0;
		caps_m       = 1'b0;
		lfsr_state   = 32'h6804503c;
		edge_cnt     = 0;
		cycles       = 0;
		cycle_limit  = 0;

		tap(1'b0, 8'h1C); // Letters, shift and caps
		add(1'b1, 1'b0, 8'h12);
		tap(1'b0, 8'h1C);
		add(1'b0, 1'b0, 8'h12);
		tap(1'b0, 8'h58);
		tap(1'b0, 8'h32);
		add(1'b1, 1'b0, 8'h59);
		tap(1'b0, 8'h32);
		add(1'b0, 1'b0, 8'h59);
		tap(1'b0, 8'h58);
		tap(1'b0, 8'h16); // Digits and punctuation
		tap(1'b0, 8'h70);
		add(1'b1, 1'b0, 8'h12);
		tap(1'b0, 8'h45);
		tap(1'b0, 8'h41);
		add(1'b0, 1'b0, 8'h12);
		tap(1'b0, 8'h4E);
		tap(1'b0, 8'h0E);
		tap(1'b0, 8'h5A); // Editing keys
		tap(1'b1, 8'h5A);
		tap(1'b0, 8'h29);
		tap(1'b0, 8'h66);
		tap(1'b1, 8'h6B);
		tap(1'b1, 8'h74);
		tap(1'b0, 8'h54);
		add(1'b1, 1'b0, 8'h14); // Ctrl combinations
		tap(1'b0, 8'h21);
		tap(1'b0, 8'h22);
		tap(1'b0, 8'h0E);
		tap(1'b0, 8'h1C);
		add(1'b0, 1'b0, 8'h14);
		add(1'b1, 1'b1, 8'h14);
		tap(1'b0, 8'h22);
		add(1'b0, 1'b1, 8'h14);
		tap(1'b0, 8'h07); // Unmapped
		add(1'b1, 1'b0, 8'h23); // Key repeat
		add(1'b1, 1'b0, 8'h23);
		add(1'b0, 1'b0, 8'h23);
		add(1'b1, 1'b0, 8'h24); // Rollover
		add(1'b1, 1'b0, 8'h2B);
		add(1'b0, 1'b0, 8'h2B);
		add(1'b0, 1'b0, 8'h24);
		cycle_limit = ev_q.size() * 700 + 1000;

		repeat (3) @(posedge CLK12);
		#2;
		RESET = 1'b0;
		repeat (300) @(posedge CLK12); // Cross one drain edge with an empty ring
		#2;
		check(32'(key_byte), 0, "key_byte before the first event");
		check(32'(upcase), 0, "upcase before the first event");
		foreach (ev_q[i])
			issue_event(ev_q[i]);

		if (exp_q.size() == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("%0d expected key bytes never reached the port", exp_q.size());
			stop_run();
		end
	end

endmodule

`default_nettype wire

// ==== tests/abc80_kbd_assert.sv ====
// Concurrent checks on the key ring pacing, ring room and caps toggle
`include "abc80_kbd_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module abc80_kbd_assert (
	input logic                        CLK12,
	input logic                        RESET,
	input logic [`KEY_QUEUE_IDX_W-1:0] rd_idx,
	input logic [`KEY_QUEUE_IDX_W-1:0] wr_idx,
	input logic [`KEY_PACE_W-1:0]      pace_cnt,
	input logic                        entry_stb,
	input logic                        key_strobe,
	input logic                        key_pressed,
	input logic                        key_extended,
	input logic [7:0]                  key_code,
	input logic                        upcase
);

	logic                        caps_press;
	logic [`KEY_QUEUE_IDX_W-1:0] unread;

	assign caps_press = key_strobe && key_pressed && !key_extended && key_code == `SC_CAPS;
	assign unread     = wr_idx - rd_idx; // Entries not yet shown

	rd_on_wrap: assert property (@(posedge CLK12) disable iff (RESET)
		!(&pace_cnt) |=> $stable(rd_idx))
		else $error("Read index moved between drain edges");

	// A rollover pair must still fit without reaching the read slot
	ring_room: assert property (@(posedge CLK12) disable iff (RESET)
		entry_stb |-> ({1'b0, unread} + 4'd2) < 4'(`KEY_QUEUE_DEPTH))
		else $error("Key ring would hold more than seven unread entries");

	caps_toggles: assert property (@(posedge CLK12) disable iff (RESET)
		caps_press |=> upcase != $past(upcase))
		else $error("Caps press did not toggle upcase");

	caps_only: assert property (@(posedge CLK12) disable iff (RESET)
		upcase != $past(upcase) |-> $past(caps_press))
		else $error("upcase changed without a caps press");

endmodule

bind abc80_kbd abc80_kbd_assert u_assert (
	.CLK12        (CLK12),
	.RESET        (RESET),
	.rd_idx       (u_queue.rd_idx),
	.wr_idx       (u_queue.wr_idx),
	.pace_cnt     (u_queue.pace_cnt),
	.entry_stb    (entry_stb),
	.key_strobe   (key_strobe),
	.key_pressed  (key_pressed),
	.key_extended (key_extended),
	.key_code     (key_code),
	.upcase       (upcase)
);

`default_nettype wire

// ==== verilog/abc80_kbd.sv ====
// Keyboard unit top level with control, translation table and key ring
`timescale 1ns/1ps
`default_nettype none

module abc80_kbd import abc80_kbd_pkg::*; (
	input  logic       CLK12,
	input  logic       RESET,
	input  logic       key_strobe,
	input  logic       key_pressed,
	input  logic       key_extended,
	input  logic [7:0] key_code, // PS/2 set 2 code
	output key_entry_t key_byte,
	output logic       upcase
);

	logic       shift;
	logic       ctrl;
	logic       hit;
	abc_code_t  code;
	logic       entry_stb;
	key_entry_t entry;

	kbd_control u_control (
		.CLK12        (CLK12),
		.RESET        (RESET),
		.key_strobe   (key_strobe),
		.key_pressed  (key_pressed),
		.key_extended (key_extended),
		.key_code     (key_code),
		.hit          (hit),
		.code         (code),
		.shift        (shift),
		.ctrl         (ctrl),
		.upcase       (upcase),
		.entry_stb    (entry_stb),
		.entry        (entry)
	);

	// Table sees the live key and the registered modifiers
	scancode_map u_map (
		.scan   ({key_extended, key_code}),
		.shift  (shift),
		.ctrl   (ctrl),
		.upcase (upcase),
		.hit    (hit),
		.code   (code)
	);

	key_queue u_queue (
		.CLK12     (CLK12),
		.RESET     (RESET),
		.entry_stb (entry_stb),
		.entry     (entry),
		.key_byte  (key_byte)
	);

endmodule

`default_nettype wire

// ==== verilog/key_queue.sv ====
// Key entry ring with rollover release insertion and paced draining
`include "abc80_kbd_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module key_queue import abc80_kbd_pkg::*; (
	input  logic       CLK12,
	input  logic       RESET,
	input  logic       entry_stb,
	input  key_entry_t entry,
	output key_entry_t key_byte
);

	localparam logic [`KEY_QUEUE_IDX_W-1:0] IDX_ONE = 1;
	localparam logic [`KEY_QUEUE_IDX_W-1:0] IDX_TWO = 2;

	key_entry_t                  ring [`KEY_QUEUE_DEPTH];
	logic [`KEY_QUEUE_IDX_W-1:0] wr_idx; // Slot of the newest entry
	logic [`KEY_QUEUE_IDX_W-1:0] rd_idx; // Slot shown on the port
	logic [`KEY_QUEUE_IDX_W-1:0] wr_next1;
	logic [`KEY_QUEUE_IDX_W-1:0] wr_next2;
	logic [`KEY_PACE_W-1:0]      pace_cnt;
	key_entry_t                  last;
	logic                        rollover;

	assign last     = ring[wr_idx];
	assign wr_next1 = wr_idx + IDX_ONE;
	assign wr_next2 = wr_idx + IDX_TWO;

	// New make while the last entry is still a make
	assign rollover = entry.pressed && last.pressed;

	// ==========================================================================
	// Write side
	// ==========================================================================

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			for (int i = 0; i < `KEY_QUEUE_DEPTH; i++)
				ring[i] <= '0;
			wr_idx <= '0;
		end else if (entry_stb && entry != last) begin // Repeats dropped
			if (rollover) begin
				ring[wr_next1].pressed <= 1'b0; // Break for the held key
				ring[wr_next1].code    <= last.code;
				ring[wr_next2]         <= entry;
				wr_idx                 <= wr_next2;
			end else begin
				ring[wr_next1] <= entry;
				wr_idx         <= wr_next1;
			end
		end
	end

	// ==========================================================================
	// Read side, one step per counter wrap
	// ==========================================================================

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			pace_cnt <= '0;
			rd_idx   <= '0;
		end else begin
			pace_cnt <= pace_cnt + 1'b1; // Free running
			if (&pace_cnt && rd_idx != wr_idx)
				rd_idx <= rd_idx + IDX_ONE;
		end
	end

	assign key_byte = ring[rd_idx];

endmodule

`default_nettype wire

// ==== verilog/kbd_control.sv ====
// Modifier tracking, caps toggle and issue of translated key entries
`include "abc80_kbd_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module kbd_control import abc80_kbd_pkg::*; (
	input  logic       CLK12,
	input  logic       RESET,
	input  logic       key_strobe,
	input  logic       key_pressed,
	input  logic       key_extended,
	input  logic [7:0] key_code,
	input  logic       hit,
	input  abc_code_t  code,
	output logic       shift,
	output logic       ctrl,
	output logic       upcase,
	output logic       entry_stb,
	output key_entry_t entry
);

	logic is_shift;
	logic is_ctrl;
	logic is_caps;

	// ==========================================================================
	// Modifier decode
	// ==========================================================================

	assign is_shift = !key_extended && (key_code == `SC_LSHIFT || key_code == `SC_RSHIFT);
	assign is_ctrl  = key_code == `SC_CTRL; // Left or right ctrl
	assign is_caps  = !key_extended && key_code == `SC_CAPS;

	always_ff @(posedge CLK12) begin
		if (RESET) begin
			shift     <= 1'b0;
			ctrl      <= 1'b0;
			upcase    <= 1'b0;
			entry_stb <= 1'b0;
		end else begin
			entry_stb <= 1'b0; // Strobe lasts one cycle
			if (key_strobe) begin
				if (is_shift) begin
					shift <= key_pressed;
				end else if (is_ctrl) begin
					ctrl <= key_pressed;
				end else if (is_caps) begin
					if (key_pressed)
						upcase <= ~upcase; // Toggle on make only
				end else if (hit) begin
					entry_stb <= 1'b1;
				end
			end
		end
	end

	// Code was looked up with the modifiers in force before this strobe
	always_ff @(posedge CLK12) begin
		if (key_strobe && hit) begin
			entry.pressed <= key_pressed;
			entry.code    <= code;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/scancode_map.sv ====
// Scan code to machine character code translation table
`timescale 1ns/1ps
`default_nettype none

module scancode_map import abc80_kbd_pkg::*; (
	input  scan_t     scan,
	input  logic      shift,
	input  logic      ctrl,
	input  logic      upcase,
	output logic      hit,
	output abc_code_t code
);

	// Lower case is selected when shift and caps agree
	abc_code_t case_mask;

	assign case_mask = {1'b0, shift == upcase, 5'd0};

	always_comb begin
		hit  = 1'b1;
		code = '0;
		casez ({ctrl, shift, scan})
			// ==================================================================
			// Letters, ctrl low
			// ==================================================================
			{2'b0?, 9'h01C}: code = 7'h41 | case_mask; // A
			{2'b0?, 9'h032}: code = 7'h42 | case_mask; // B
			{2'b0?, 9'h021}: code = 7'h43 | case_mask; // C
			{2'b0?, 9'h023}: code = 7'h44 | case_mask; // D
			{2'b0?, 9'h024}: code = 7'h45 | case_mask; // E
			{2'b0?, 9'h02B}: code = 7'h46 | case_mask; // F
			{2'b0?, 9'h034}: code = 7'h47 | case_mask; // G
			{2'b0?, 9'h033}: code = 7'h48 | case_mask; // H
			{2'b0?, 9'h043}: code = 7'h49 | case_mask; // I
			{2'b0?, 9'h03B}: code = 7'h4A | case_mask; // J
			{2'b0?, 9'h042}: code = 7'h4B | case_mask; // K
			{2'b0?, 9'h04B}: code = 7'h4C | case_mask; // L
			{2'b0?, 9'h03A}: code = 7'h4D | case_mask; // M
			{2'b0?, 9'h031}: code = 7'h4E | case_mask; // N
			{2'b0?, 9'h044}: code = 7'h4F | case_mask; // O
			{2'b0?, 9'h04D}: code = 7'h50 | case_mask; // P
			{2'b0?, 9'h015}: code = 7'h51 | case_mask; // Q
			{2'b0?, 9'h02D}: code = 7'h52 | case_mask; // R
			{2'b0?, 9'h01B}: code = 7'h53 | case_mask; // S
			{2'b0?, 9'h02C}: code = 7'h54 | case_mask; // T
			{2'b0?, 9'h03C}: code = 7'h55 | case_mask; // U
			{2'b0?, 9'h02A}: code = 7'h56 | case_mask; // V
			{2'b0?, 9'h01D}: code = 7'h57 | case_mask; // W
			{2'b0?, 9'h022}: code = 7'h58 | case_mask; // X
			{2'b0?, 9'h035}: code = 7'h59 | case_mask; // Y
			{2'b0?, 9'h01A}: code = 7'h5A | case_mask; // Z

			// ==================================================================
			// Digits
			// ==================================================================
			{2'b00, 9'h016}: code = 7'h31; // 1
			{2'b00, 9'h01E}: code = 7'h32; // 2
			{2'b00, 9'h026}: code = 7'h33; // 3
			{2'b00, 9'h025}: code = 7'h34; // 4
			{2'b00, 9'h02E}: code = 7'h35; // 5
			{2'b00, 9'h036}: code = 7'h36; // 6
			{2'b00, 9'h03D}: code = 7'h37; // 7
			{2'b00, 9'h03E}: code = 7'h38; // 8
			{2'b00, 9'h046}: code = 7'h39; // 9
			{2'b00, 9'h045}: code = 7'h30; // 0

			{2'b00, 9'h069}: code = 7'h31; // Keypad 1
			{2'b00, 9'h072}: code = 7'h32; // Keypad 2
			{2'b00, 9'h07A}: code = 7'h33; // Keypad 3
			{2'b00, 9'h06B}: code = 7'h34; // Keypad 4
			{2'b00, 9'h073}: code = 7'h35; // Keypad 5
			{2'b00, 9'h074}: code = 7'h36; // Keypad 6
			{2'b00, 9'h06C}: code = 7'h37; // Keypad 7
			{2'b00, 9'h075}: code = 7'h38; // Keypad 8
			{2'b00, 9'h07D}: code = 7'h39; // Keypad 9
			{2'b00, 9'h070}: code = 7'h30; // Keypad 0

			// Shifted row, keypad has no shifted form
			{2'b01, 9'h016}: code = 7'h21; // !
			{2'b01, 9'h01E}: code = 7'h22; // Double quote
			{2'b01, 9'h026}: code = 7'h23; // #
			{2'b01, 9'h025}: code = 7'h24; // $
			{2'b01, 9'h02E}: code = 7'h25; // %
			{2'b01, 9'h036}: code = 7'h26; // &
			{2'b01, 9'h03D}: code = 7'h27; // Apostrophe
			{2'b01, 9'h03E}: code = 7'h28; // (
			{2'b01, 9'h046}: code = 7'h29; // )
			{2'b01, 9'h045}: code = 7'h3D; // =

			// ==================================================================
			// Editing and control keys
			// ==================================================================
			{2'b00, 1'b?, 8'h5A}: code = 7'h0D; // Enter, main or keypad
			{2'b00, 9'h029}: code = 7'h20; // Space
			{2'b00, 9'h16B}: code = 7'h08; // Left arrow
			{2'b00, 9'h066}: code = 7'h08; // Backspace
			{2'b00, 9'h174}: code = 7'h09; // Right arrow
			{2'b10, 9'h021}: code = 7'h03; // Ctrl-C
			{2'b10, 9'h022}: code = 7'h18; // Ctrl-X

			// ==================================================================
			// Punctuation
			// ==================================================================
			{2'b00, 9'h041}: code = 7'h2C; // ,
			{2'b00, 9'h049}: code = 7'h2E; // .
			{2'b00, 9'h04A}: code = 7'h2D; // -
			{2'b00, 9'h04E}: code = 7'h2B; // +
			{2'b00, 9'h05D}: code = 7'h27; // Apostrophe key
			{2'b00, 9'h00E}: code = 7'h3C; // Backtick gives <

			{2'b01, 9'h041}: code = 7'h3B; // ;
			{2'b01, 9'h049}: code = 7'h3A; // :
			{2'b01, 9'h04A}: code = 7'h5F; // _
			{2'b01, 9'h04E}: code = 7'h3F; // ?
			{2'b01, 9'h05D}: code = 7'h2A; // *
			{2'b01, 9'h00E}: code = 7'h3E; // >
			{2'b1?, 9'h00E}: code = 7'h7F; // Ctrl-backtick is delete

			// National letters follow the case rule like A to Z
			{2'b0?, 9'h055}: code = 7'h40 | case_mask; // Accented E
			{2'b0?, 9'h054}: code = 7'h5D | case_mask; // [
			{2'b0?, 9'h05B}: code = 7'h5E | case_mask; // ]
			{2'b0?, 9'h04C}: code = 7'h5C | case_mask; // ;
			{2'b0?, 9'h052}: code = 7'h5B | case_mask; // Quote

			default: hit = 1'b0; // Not a translated key
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/abc80_kbd_pkg.sv ====
// Scan-code, character-code and key ring entry types
`default_nettype none

package abc80_kbd_pkg;

	// Incoming PS/2 key, with the E0 prefix folded into one bit
	typedef struct packed {
		logic       extended; // Key came with E0 prefix
		logic [7:0] code; // Set 2 scan code
	} scan_t;

	// Machine character code
	typedef logic [6:0] abc_code_t;

	// Ring payload, also the byte seen on the key port
	typedef struct packed {
		logic      pressed; // 1 for make, 0 for break
		abc_code_t code;
	} key_entry_t;

endpackage

`default_nettype wire

// ==== verilog/abc80_kbd_macros.svh ====
// Keyboard ring sizing, drain pacing and modifier scan codes
`ifndef ABC80_KBD_MACROS_SVH
`define ABC80_KBD_MACROS_SVH

`default_nettype none

// ==========================================================================
// Key ring
// ==========================================================================

`define KEY_QUEUE_DEPTH 8 // Entries in the ring
`define KEY_QUEUE_IDX_W 3 // Ring index width

// One drain opportunity each time this counter wraps
`define KEY_PACE_W 8

// ==========================================================================
// PS/2 set 2 modifier codes
// ==========================================================================

`define SC_LSHIFT 8'h12 // Left shift
`define SC_RSHIFT 8'h59 // Right shift
`define SC_CTRL 8'h14 // Either ctrl, E0 prefix ignored
`define SC_CAPS 8'h58 // Caps lock

`default_nettype wire

`endif
